// File: rtl/arb_settings.svh
`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

// number of requesters sharing the downstream port
`define ARB_NUM_REQUEST 3

// payload bits per request, critical flag travels separately
`define ARB_REQUEST_WIDTH 64

// entries per input queue, power of two
`define ARB_QUEUE_DEPTH 4

`endif

// File: rtl/arb_pkg.sv
`default_nettype none

`include "arb_settings.svh"

package arb_pkg;

    localparam int SRC_IDX_WIDTH = (`ARB_NUM_REQUEST > 1) ? $clog2(`ARB_NUM_REQUEST) : 1;

    // one request word as seen by the consumer
    typedef logic [`ARB_REQUEST_WIDTH-1:0] payload_t;

    // requester index, also reported with each output word
    typedef logic [SRC_IDX_WIDTH-1:0] src_idx_t;

    // what a queue slot holds
    typedef struct packed
    {
        logic     critical;
        payload_t payload;
    } queue_entry_t;

endpackage

`default_nettype wire

// File: rtl/req_if.sv
`default_nettype none

// valid/ack handshake with a critical flag riding next to the payload;
// a word moves in any cycle where valid and ack are both high
interface req_if
#(
    parameter type payload_type = arb_pkg::payload_t
)
();

    logic        valid;
    logic        critical;
    payload_type payload;
    logic        ack;

    modport producer
    (
        output valid,
        output critical,
        output payload,
        input  ack
    );

    modport consumer
    (
        input  valid,
        input  critical,
        input  payload,
        output ack
    );

endinterface

`default_nettype wire

// File: rtl/fifo_queue.sv
`default_nettype none

`include "arb_settings.svh"

module fifo_queue
#(
    parameter type entry_t = arb_pkg::queue_entry_t,
    parameter int  DEPTH   = `ARB_QUEUE_DEPTH // power of two
)
(
    input  logic    clk_in,
    input  logic    reset_in,

    req_if.consumer push,
    req_if.producer pop,

    output logic    is_full,
    output logic    is_empty
);

    localparam int ADDR_WIDTH = $clog2(DEPTH);

    // extra msb on each pointer tells a full buffer from an empty one
    logic [ADDR_WIDTH:0]   wr_ptr;
    logic [ADDR_WIDTH:0]   rd_ptr;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [ADDR_WIDTH-1:0] rd_addr;

    entry_t mem [DEPTH];
    entry_t wr_entry;
    entry_t rd_entry;

    logic do_push;
    logic do_pop;

    assign wr_addr = wr_ptr[ADDR_WIDTH-1:0];
    assign rd_addr = rd_ptr[ADDR_WIDTH-1:0];

    assign is_empty = (wr_ptr == rd_ptr);
    assign is_full  = (wr_addr == rd_addr) && (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]);

    // upstream side, back-pressure is just a full buffer
    assign push.ack = ~is_full;
    assign do_push  = push.valid & push.ack;

    always_comb
    begin
        wr_entry.critical = push.critical;
        wr_entry.payload  = push.payload;
    end

    // head of the queue is shown straight from the buffer
    assign rd_entry     = mem[rd_addr];
    assign pop.valid    = ~is_empty;
    assign pop.critical = rd_entry.critical;
    assign pop.payload  = rd_entry.payload;
    assign do_pop       = pop.valid & pop.ack;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr <= '0;
        end
        else if (do_push)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            rd_ptr <= '0;
        end
        else if (do_pop)
        begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (do_push)
        begin
            mem[wr_addr] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

// File: rtl/priority_arbiter.sv
`default_nettype none

`include "arb_settings.svh"

module priority_arbiter
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    req_if.consumer                     heads [`ARB_NUM_REQUEST],
    input  logic [`ARB_NUM_REQUEST-1:0] queue_full,

    output arb_pkg::payload_t           request_out,
    output arb_pkg::src_idx_t           request_source,
    output logic                        request_valid,
    input  logic                        issue_ack_in
);

    import arb_pkg::*;

    localparam int NUM = `ARB_NUM_REQUEST;

    logic [NUM-1:0] head_valid;
    logic [NUM-1:0] head_crit;
    payload_t       head_payload [NUM];

    // position k of the rotated vectors is source last+1+k
    logic [NUM-1:0] rot_valid;
    logic [NUM-1:0] rot_crit;

    logic           any_crit;
    logic           grant_found;
    src_idx_t       grant_src;
    logic           load_en;

    for (genvar i = 0; i < NUM; i++)
    begin : g_head
        assign head_valid[i]   = heads[i].valid;
        assign head_crit[i]    = heads[i].critical | queue_full[i]; // stalled queue escalates
        assign head_payload[i] = heads[i].payload;

        // pop only the entry that is leaving the output register
        assign heads[i].ack = request_valid & issue_ack_in & (request_source == src_idx_t'(i));
    end

    // new word may enter when the register is empty or being emptied
    assign load_en = ~request_valid | issue_ack_in;

    always_comb
    begin
        int pos;
        pos       = 0;
        rot_valid = '0;
        rot_crit  = '0;
        for (int k = 0; k < NUM; k++)
        begin
            pos          = (int'(request_source) + 1 + k) % NUM;
            rot_valid[k] = head_valid[pos];
            rot_crit[k]  = head_crit[pos];
        end
        // last source sits at the end of the rotation, its head is
        // still the word in the output register while valid
        if (request_valid)
        begin
            rot_valid[NUM-1] = 1'b0;
        end
    end

    assign any_crit    = |(rot_valid & rot_crit);
    assign grant_found = |rot_valid;

    // scan downwards so the lowest rotated position wins
    always_comb
    begin
        int off;
        off = 0;
        if (any_crit)
        begin
            for (int k = NUM - 1; k >= 0; k--)
            begin
                if (rot_valid[k] && rot_crit[k])
                begin
                    off = k;
                end
            end
        end
        else
        begin
            for (int k = NUM - 1; k >= 0; k--)
            begin
                if (rot_valid[k])
                begin
                    off = k;
                end
            end
        end
        grant_src = src_idx_t'((int'(request_source) + 1 + off) % NUM);
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            request_valid  <= 1'b0;
            request_source <= '0;
        end
        else if (load_en)
        begin
            request_valid <= grant_found;
            if (grant_found)
            begin
                request_source <= grant_src; // round robin resumes after this one
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load_en && grant_found)
        begin
            request_out <= head_payload[grant_src];
        end
    end

endmodule

`default_nettype wire

// File: rtl/arb_subsystem_top.sv
`default_nettype none

`include "arb_settings.svh"

module arb_subsystem_top
(
    input  logic                                           clk_in,
    input  logic                                           reset_in,

    input  logic [`ARB_NUM_REQUEST*`ARB_REQUEST_WIDTH-1:0] request_flat,
    input  logic [`ARB_NUM_REQUEST-1:0]                    request_valid_flat,
    input  logic [`ARB_NUM_REQUEST-1:0]                    request_critical_flat,
    output logic [`ARB_NUM_REQUEST-1:0]                    issue_ack_flat,

    output arb_pkg::payload_t                              request_out,
    output arb_pkg::src_idx_t                              request_source,
    output logic                                           request_valid,
    input  logic                                           issue_ack_in
);

    import arb_pkg::*;

    localparam int NUM   = `ARB_NUM_REQUEST;
    localparam int WIDTH = `ARB_REQUEST_WIDTH;

    logic [NUM-1:0] queue_full;

    // requester side of each queue
    req_if #(.payload_type(payload_t)) up_if [NUM] ();

    // head of each queue towards the arbiter
    req_if #(.payload_type(payload_t)) head_if [NUM] ();

    for (genvar i = 0; i < NUM; i++)
    begin : g_queue
        assign up_if[i].valid    = request_valid_flat[i];
        assign up_if[i].critical = request_critical_flat[i];
        assign up_if[i].payload  = request_flat[i*WIDTH +: WIDTH];
        assign issue_ack_flat[i] = up_if[i].ack; // drops while the queue is full

        fifo_queue
        #(
            .entry_t  (queue_entry_t),
            .DEPTH    (`ARB_QUEUE_DEPTH)
        )
        u_queue
        (
            .clk_in   (clk_in),
            .reset_in (reset_in),
            .push     (up_if[i]),
            .pop      (head_if[i]),
            .is_full  (queue_full[i]),
            .is_empty ()
        );
    end

    priority_arbiter u_arbiter
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .heads          (head_if),
        .queue_full     (queue_full),
        .request_out    (request_out),
        .request_source (request_source),
        .request_valid  (request_valid),
        .issue_ack_in   (issue_ack_in)
    );

endmodule

`default_nettype wire

// File: tb/arb_checker.sv
`default_nettype none

`include "arb_settings.svh"

module arb_checker
(
    input  logic                                           clk_in,
    input  logic                                           reset_in,
    input  logic [`ARB_NUM_REQUEST*`ARB_REQUEST_WIDTH-1:0] request_flat,
    input  logic [`ARB_NUM_REQUEST-1:0]                    request_valid_flat,
    input  logic [`ARB_NUM_REQUEST-1:0]                    issue_ack_flat,
    input  arb_pkg::payload_t                              request_out,
    input  arb_pkg::src_idx_t                              request_source,
    input  logic                                           request_valid,
    input  logic                                           issue_ack_in,
    output int                                             error_count
);

    import arb_pkg::*;

    localparam int NUM   = `ARB_NUM_REQUEST;
    localparam int WIDTH = `ARB_REQUEST_WIDTH;

    string          test_name  = "reset";
    int             errors     = 0;
    int             pend_src   [$]; // words of all sources in push order
    payload_t       pend_data  [$];
    int             exp_src    [$]; // grant order still expected in this test
    logic [NUM-1:0] full_probe = '0;
    bit             seen_reset = 1'b0;
    bit             hold_check = 1'b0;
    bit             last_xfer  = 1'b0;
    src_idx_t       last_src;
    payload_t       held_out;
    src_idx_t       held_src;

    assign error_count = errors;

    task automatic report_mismatch(string what, logic [WIDTH-1:0] expected,
                                   logic [WIDTH-1:0] actual);
        $display("** Error %s: %s, expected %0h, actual %0h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic report_failure(string msg);
        $display("Failure in %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic begin_test(string name, int e0, int e1, int e2, int len);
        test_name = name;
        exp_src.delete();
        if (len > 0) exp_src.push_back(e0);
        if (len > 1) exp_src.push_back(e1);
        if (len > 2) exp_src.push_back(e2);
    endtask

    // compared on the next edge, while the downstream side is still stalled
    task automatic expect_full(int src);
        full_probe[src] = 1'b1;
    endtask

    task automatic flush_pending();
        if (pend_src.size() > 0)
            report_failure($sformatf("%0d pushed words never came out", pend_src.size()));
        if (exp_src.size() > 0)
            report_failure($sformatf("%0d expected grants never happened", exp_src.size()));
        pend_src.delete();
        pend_data.delete();
        exp_src.delete();
    endtask

    task automatic compare_output();
        int found;
        int want;
        found = -1;
        // the first pending word of a source is its oldest
        for (int k = 0; k < pend_src.size(); k++)
            if (found < 0 && pend_src[k] == int'(request_source)) found = k;
        if (found < 0)
        begin
            report_failure($sformatf("source %0d sent a word it never pushed", request_source));
        end
        else
        begin
            if (pend_data[found] !== request_out)
                report_mismatch($sformatf("payload of source %0d", request_source),
                                pend_data[found], request_out);
            pend_src.delete(found);
            pend_data.delete(found);
        end
        if (exp_src.size() > 0)
        begin
            want = exp_src.pop_front();
            if (want != int'(request_source)) report_mismatch("grant source", want, request_source);
        end
        if (last_xfer && last_src == request_source)
            report_failure($sformatf("source %0d sent in two adjacent cycles", request_source));
    endtask

    always @(posedge clk_in)
    begin
        if (reset_in)
        begin
            flush_pending();
            seen_reset = 1'b1;
            hold_check = 1'b0;
            last_xfer  = 1'b0;
            full_probe = '0;
        end
        else
        begin
            if (seen_reset && request_valid !== 1'b0)
                report_mismatch("request_valid after reset", 0, request_valid);
            seen_reset = 1'b0;
            if (hold_check) // stalled last cycle, nothing may move
            begin
                if (request_valid !== 1'b1) report_mismatch("held request_valid", 1, request_valid);
                if (request_out !== held_out) report_mismatch("held request_out", held_out, request_out);
                if (request_source !== held_src)
                    report_mismatch("held request_source", held_src, request_source);
            end
            for (int i = 0; i < NUM; i++)
            begin
                if (full_probe[i] && issue_ack_flat[i] !== 1'b0)
                    report_mismatch($sformatf("upstream ack of full queue %0d", i), 0, issue_ack_flat[i]);
                if (request_valid_flat[i] && issue_ack_flat[i])
                begin
                    pend_src.push_back(i);
                    pend_data.push_back(request_flat[i*WIDTH +: WIDTH]);
                end
            end
            full_probe = '0;
            if (request_valid && issue_ack_in) compare_output();
            last_xfer  = request_valid && issue_ack_in;
            last_src   = request_source;
            hold_check = request_valid && !issue_ack_in;
            held_out   = request_out;
            held_src   = request_source;
        end
    end

endmodule

`default_nettype wire

// File: tb/arb_tb.sv
`default_nettype none

`include "arb_settings.svh"

module arb_tb;

    import arb_pkg::*;

    localparam int          NUM      = `ARB_NUM_REQUEST;
    localparam int          WIDTH    = `ARB_REQUEST_WIDTH;
    localparam int          NUM_ROWS = 7;
    localparam logic [31:0] LCG_MUL  = 32'd1103515245;
    localparam logic [31:0] LCG_INC  = 32'd12345;

    logic                 clk_in;
    logic                 reset_in;
    logic [NUM*WIDTH-1:0] request_flat;
    logic [NUM-1:0]       request_valid_flat;
    logic [NUM-1:0]       request_critical_flat;
    logic [NUM-1:0]       issue_ack_flat;
    payload_t             request_out;
    src_idx_t             request_source;
    logic                 request_valid;
    logic                 issue_ack_in;

    int          checker_errors;
    int          tb_errors   = 0;
    int          total_xfers = 0;
    logic [31:0] lcg_state   = 32'd66;
    bit          table_ready = 1'b0;

    string          row_name      [NUM_ROWS];
    logic [NUM-1:0] row_req_mask  [NUM_ROWS];
    logic [NUM-1:0] row_crit_mask [NUM_ROWS];
    int             row_count     [NUM_ROWS][3];
    int             row_stall     [NUM_ROWS]; // downstream stall percentage
    bit             row_preload   [NUM_ROWS];
    bit             row_in_order  [NUM_ROWS]; // requesters push one after another
    int             row_exp       [NUM_ROWS][3];
    int             row_exp_len   [NUM_ROWS];

    arb_subsystem_top u_dut
    (
        .clk_in                (clk_in),
        .reset_in              (reset_in),
        .request_flat          (request_flat),
        .request_valid_flat    (request_valid_flat),
        .request_critical_flat (request_critical_flat),
        .issue_ack_flat        (issue_ack_flat),
        .request_out           (request_out),
        .request_source        (request_source),
        .request_valid         (request_valid),
        .issue_ack_in          (issue_ack_in)
    );

    arb_checker u_checker
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .request_flat       (request_flat),
        .request_valid_flat (request_valid_flat),
        .issue_ack_flat     (issue_ack_flat),
        .request_out        (request_out),
        .request_source     (request_source),
        .request_valid      (request_valid),
        .issue_ack_in       (issue_ack_in),
        .error_count        (checker_errors)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * LCG_MUL + LCG_INC;
        return lcg_state >> 8; // low bits of the state repeat too quickly
    endfunction

    task automatic add_row(int r, string name, logic [2:0] req_mask, logic [2:0] crit_mask,
                           int c0, int c1, int c2, int stall, bit preload, bit in_order,
                           int e0, int e1, int e2, int exp_len);
        row_name[r]      = name;
        row_req_mask[r]  = req_mask;
        row_crit_mask[r] = crit_mask;
        row_count[r][0]  = c0;
        row_count[r][1]  = c1;
        row_count[r][2]  = c2;
        row_stall[r]     = stall;
        row_preload[r]   = preload;
        row_in_order[r]  = in_order;
        row_exp[r][0]    = e0;
        row_exp[r][1]    = e1;
        row_exp[r][2]    = e2;
        row_exp_len[r]   = exp_len;
    endtask

    task automatic fill_table();
        // name, req mask, crit mask, counts, stall %, preload, in order, first grants
        add_row(0, "rr_fairness",     3'b111, 3'b000,  1,  1,  1,  0, 1, 0, 1, 2, 0, 3);
        add_row(1, "critical_first",  3'b111, 3'b100,  1,  1,  1,  0, 1, 0, 2, 0, 1, 3);
        add_row(2, "full_escalation", 3'b011, 3'b000,  4,  1,  0,  0, 1, 1, 0, 1, 0, 3);
        add_row(3, "random_light",    3'b111, 3'b000, 12, 12, 12, 20, 0, 0, 0, 0, 0, 0);
        add_row(4, "random_heavy",    3'b111, 3'b010, 16,  8, 16, 60, 0, 0, 0, 0, 0, 0);
        add_row(5, "single_source",   3'b001, 3'b000, 10,  0,  0, 30, 0, 0, 0, 0, 0, 0);
        // full queue 2 jumps ahead of source 1, which round robin would pick next
        add_row(6, "full_overtakes",  3'b111, 3'b000,  1,  1,  4,  0, 1, 1, 0, 2, 1, 3);
    endtask

    task automatic apply_reset();
        @(posedge clk_in);
        #1;
        reset_in           = 1'b1;
        request_valid_flat = '0;
        issue_ack_in       = 1'b0;
        repeat (4) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
    endtask

    task automatic run_row(int r);
        int             pending [3];
        int             seq [3];
        int             total;
        int             done;
        int             cycles;
        int             first;
        bit             stalling;
        logic [NUM-1:0] accepted;
        total  = 0;
        done   = 0;
        cycles = 0;
        for (int i = 0; i < NUM; i++)
        begin
            pending[i] = row_req_mask[r][i] ? row_count[r][i] : 0;
            seq[i]     = 0;
            total     += pending[i];
        end
        stalling              = row_preload[r];
        request_critical_flat = row_crit_mask[r];
        u_checker.begin_test(row_name[r], row_exp[r][0], row_exp[r][1], row_exp[r][2],
                             row_exp_len[r]);
        while (done < total && cycles <= total * 20 + 50)
        begin
            first = NUM;
            for (int i = NUM - 1; i >= 0; i--)
                if (pending[i] > 0) first = i;
            for (int i = 0; i < NUM; i++)
            begin
                if (!request_valid_flat[i] && pending[i] > 0 && (!row_in_order[r] || i == first)
                    && (row_preload[r] || lcg_next() % 4 != 0))
                begin
                    // source tag and sequence number in the upper half
                    request_flat[i*WIDTH +: WIDTH] = {8'(i), 24'(seq[i]), lcg_next()};
                    request_valid_flat[i]          = 1'b1;
                    seq[i]++;
                end
            end
            if (stalling && first == NUM)
            begin
                for (int i = 0; i < NUM; i++)
                    if (row_req_mask[r][i] && row_count[r][i] == `ARB_QUEUE_DEPTH)
                        u_checker.expect_full(i);
                stalling = 1'b0; // all words queued, release the consumer
            end
            issue_ack_in = !stalling && (lcg_next() % 100 >= row_stall[r]);
            @(posedge clk_in);
            accepted = request_valid_flat & issue_ack_flat;
            if (request_valid && issue_ack_in) done++;
            #1;
            for (int i = 0; i < NUM; i++)
            begin
                if (accepted[i])
                begin
                    pending[i]--;
                    request_valid_flat[i] = 1'b0;
                end
            end
            cycles++;
        end
        issue_ack_in = 1'b0;
        total_xfers += done;
        if (done < total)
        begin
            $display("drain timeout in %s: only %0d of %0d words came out",
                     row_name[r], done, total);
            tb_errors++;
        end
    endtask

    initial
    begin
        reset_in              = 1'b1;
        request_flat          = '0;
        request_valid_flat    = '0;
        request_critical_flat = '0;
        issue_ack_in          = 1'b0;
        fill_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            if (r > 0) apply_reset(); // every scenario starts from last source 0
            run_row(r);
        end
        apply_reset(); // leftover words show up at this reset
        $display("%0d scenarios, %0d words out, %0d checker errors, %0d testbench errors",
                 NUM_ROWS, total_xfers, checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        int limit;
        wait (table_ready);
        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++)
            for (int i = 0; i < NUM; i++)
                if (row_req_mask[r][i]) limit += 20 * row_count[r][i];
        repeat (limit) @(posedge clk_in);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/arb_pkg.sv
rtl/req_if.sv
rtl/fifo_queue.sv
rtl/priority_arbiter.sv
rtl/arb_subsystem_top.sv
tb/arb_checker.sv
tb/arb_tb.sv

// File: Bender.yml
package:
  name: arb_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/arb_pkg.sv
      - rtl/req_if.sv
      - rtl/fifo_queue.sv
      - rtl/priority_arbiter.sv
      - rtl/arb_subsystem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/arb_checker.sv
      - tb/arb_tb.sv
